/* design/objPkg.sv */
// Sprite engine shared definitions
// Widths, entry layout and visibility threshold for the object engine

package objPkg;

	// Table side
	typedef logic [8:0]  cpuAddrT;
	typedef logic [7:0]  byteT;

	// Sprite attributes
	typedef logic [10:0] tileT;
	typedef logic [2:0]  palT;
	// Zero is transparent
	typedef logic [3:0]  colorT;
	// Palette above color
	typedef logic [6:0]  objPixelT;
	typedef logic [7:0]  xPosT;

	// ROM side, leftmost pixel in bits 15..12
	typedef logic [15:0] romWordT;
	typedef logic [24:0] romAddrT;

	// ----------------------------------------
	// Entry layout, 4 bytes per sprite
	// ----------------------------------------
	localparam int offY    = 0;
	localparam int offAttr = 1;
	localparam int offTile = 2;
	localparam int offX    = 3;

	// Fields inside the attribute byte
	localparam int palLsb  = 3;
	localparam int flipBit = 6;

	// Rows from here up hit the current line
	localparam int visibleRowMin = 240;

endpackage

/* design/objAttrRam.sv */
// Sprite attribute table
// 512 bytes, CPU read/write port plus a read-only scan port

`timescale 1ns/1ps

module objAttrRam
	import objPkg::*;
(
	input  logic    clk,
	// CPU side
	input  cpuAddrT cpuAddr,
	input  byteT    cpuWrData,
	input  logic    cpuWe,
	output byteT    cpuRdData,
	// Scanner side
	input  cpuAddrT scanAddr,
	output byteT    scanData
);

	localparam int depth = 2 ** $bits(cpuAddrT);

	// Contents undefined at power up, like the board SRAM
	byteT mem [depth];

	// ----------------------------------------
	// CPU port
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (cpuWe) begin
			mem[cpuAddr] <= cpuWrData;
		end
		// Old byte on a same-cycle write
		cpuRdData <= mem[cpuAddr];
	end

	// ----------------------------------------
	// Scan port
	// ----------------------------------------
	// Data follows scanAddr by one cycle
	always_ff @(posedge clk) begin
		scanData <= mem[scanAddr];
	end

endmodule

/* design/objLineScanner.sv */
// Sprite line scanner
// Walks the attribute table once per line, tests each Y against the line
// and hands visible sprite rows to the row fetcher

`timescale 1ns/1ps

module objLineScanner
	import objPkg::*;
#(
	parameter int unsigned numSprites = 128
) (
	input  logic       clk,
	input  logic       rstN,
	// Line control
	input  logic       lineStart,
	input  byteT       vPos,
	output logic       busy,
	output logic       lineSwap,
	// Attribute RAM
	output cpuAddrT    scanAddr,
	input  byteT       scanData,
	// Row fetcher
	output logic       rowStart,
	output tileT       rowTile,
	output logic [3:0] rowLine,
	output palT        rowPal,
	output logic       rowFlip,
	output xPosT       rowX,
	input  logic       rowDone
);

	typedef enum logic [1:0] {scanIdle, scanRead, scanTest, scanWait} scanStateT;

	scanStateT  scanState;
	logic [6:0] entryIdx;
	logic [1:0] byteCnt;
	byteT       vPosLat;
	// First three bytes of the entry, the fourth arrives live in scanTest
	byteT       entryBytes [3];
	byteT       curBytes [4];
	byteT       row;
	logic       visible;
	logic       lastEntry;

	// Only accepted while idle
	assign lineSwap = lineStart && (scanState == scanIdle);
	assign busy = (scanState != scanIdle);
	assign scanAddr = {entryIdx, byteCnt};
	assign lastEntry = (entryIdx == 7'(numSprites - 1));

	always_comb begin
		curBytes[0] = entryBytes[0];
		curBytes[1] = entryBytes[1];
		curBytes[2] = entryBytes[2];
		curBytes[3] = scanData;
	end

	// Line offset inside the sprite
	assign row = vPosLat + curBytes[offY];
	assign visible = (row >= visibleRowMin);

	// ----------------------------------------
	// Scan FSM
	// ----------------------------------------
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			scanState <= scanIdle;
			entryIdx  <= '0;
			byteCnt   <= '0;
			rowStart  <= 1'b0;
		end else begin
			rowStart <= 1'b0;
			case (scanState)
				scanIdle: begin
					if (lineStart) begin
						entryIdx  <= '0;
						byteCnt   <= '0;
						scanState <= scanRead;
					end
				end
				// One address per cycle, bytes 0..3
				scanRead: begin
					byteCnt <= byteCnt + 2'd1;
					if (byteCnt == 2'd3) begin
						scanState <= scanTest;
					end
				end
				scanTest: begin
					if (visible) begin
						rowStart  <= 1'b1;
						scanState <= scanWait;
					end else if (lastEntry) begin
						scanState <= scanIdle;
					end else begin
						entryIdx  <= entryIdx + 7'd1;
						scanState <= scanRead;
					end
				end
				// Fetcher owns the row until rowDone
				scanWait: begin
					if (rowDone) begin
						if (lastEntry) begin
							scanState <= scanIdle;
						end else begin
							entryIdx  <= entryIdx + 7'd1;
							scanState <= scanRead;
						end
					end
				end
				default: scanState <= scanIdle;
			endcase
		end
	end

	// ----------------------------------------
	// Entry capture and row hand-off
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (lineSwap) begin
			vPosLat <= vPos;
		end
		// Data lags the address by one
		if (scanState == scanRead && byteCnt != 2'd0) begin
			entryBytes[byteCnt - 2'd1] <= scanData;
		end
		if (scanState == scanTest && visible) begin
			rowTile <= {curBytes[offAttr][2:0], curBytes[offTile]};
			rowLine <= row[3:0];
			rowPal  <= curBytes[offAttr][palLsb +: $bits(palT)];
			rowFlip <= curBytes[offAttr][flipBit];
			rowX    <= curBytes[offX];
		end
	end

endmodule

/* design/objRowFetcher.sv */
// Sprite row fetcher
// Reads four 16-bit words of one sprite row from ROM, then writes
// the 16 pixels into the line buffer, mirrored when flip-X is set

`timescale 1ns/1ps

module objRowFetcher
	import objPkg::*;
#(
	parameter romAddrT romBase = '0
) (
	input  logic       clk,
	input  logic       rstN,
	// From scanner
	input  logic       rowStart,
	input  tileT       rowTile,
	input  logic [3:0] rowLine,
	input  palT        rowPal,
	input  logic       rowFlip,
	input  xPosT       rowX,
	output logic       rowDone,
	// ROM port
	output romAddrT    romAddr,
	output logic       romReq,
	input  logic       romRdy,
	input  romWordT    romData,
	// Line buffer writes
	output logic       pixWe,
	output xPosT       pixX,
	output objPixelT   pixValue
);

	typedef enum logic [1:0] {fetchIdle, fetchReq, fetchWait, fetchDraw} fetchStateT;

	fetchStateT  fetchState;
	tileT        tileLat;
	logic [3:0]  lineLat;
	palT         palLat;
	logic        flipLat;
	xPosT        xLat;
	// Sprite column c is nibble c from the top
	logic [63:0] rowBits;
	logic [1:0]  quarter;
	logic [3:0]  pixCnt;
	logic [16:0] wordAddr;
	logic [3:0]  spriteCol;
	colorT       pixColor;

	// Tile, then row, then quarter
	assign wordAddr = {tileLat, lineLat, quarter};

	// ----------------------------------------
	// Pixel output
	// ----------------------------------------
	assign spriteCol = flipLat ? (4'd15 - pixCnt) : pixCnt;
	assign pixColor = rowBits[63 - 4 * spriteCol -: 4];
	assign pixWe = (fetchState == fetchDraw);
	// Wraps at the right edge
	assign pixX = xLat + xPosT'(pixCnt);
	assign pixValue = {palLat, pixColor};

	// ----------------------------------------
	// Fetch FSM
	// ----------------------------------------
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			fetchState <= fetchIdle;
			quarter    <= '0;
			pixCnt     <= '0;
			romReq     <= 1'b0;
			rowDone    <= 1'b0;
		end else begin
			romReq  <= 1'b0;
			rowDone <= 1'b0;
			case (fetchState)
				fetchIdle: begin
					if (rowStart) begin
						quarter    <= '0;
						fetchState <= fetchReq;
					end
				end
				fetchReq: begin
					romReq     <= 1'b1;
					fetchState <= fetchWait;
				end
				// Next request only after romRdy
				fetchWait: begin
					if (romRdy) begin
						quarter <= quarter + 2'd1;
						if (quarter == 2'd3) begin
							pixCnt     <= '0;
							fetchState <= fetchDraw;
						end else begin
							fetchState <= fetchReq;
						end
					end
				end
				fetchDraw: begin
					pixCnt <= pixCnt + 4'd1;
					if (pixCnt == 4'd15) begin
						rowDone    <= 1'b1;
						fetchState <= fetchIdle;
					end
				end
				default: fetchState <= fetchIdle;
			endcase
		end
	end

	// Row latches, ROM address and word capture
	always_ff @(posedge clk) begin
		if (fetchState == fetchIdle && rowStart) begin
			tileLat <= rowTile;
			lineLat <= rowLine;
			palLat  <= rowPal;
			flipLat <= rowFlip;
			xLat    <= rowX;
		end
		if (fetchState == fetchReq) begin
			romAddr <= romBase | romAddrT'({wordAddr, 1'b0});
		end
		if (fetchState == fetchWait && romRdy) begin
			rowBits[63 - 16 * quarter -: 16] <= romData;
		end
	end

endmodule

/* design/objLineBuffer.sv */
// Sprite line buffers
// Two 256-pixel buffers swapped each line: one is built by the fetcher,
// the other is read out to the display and cleared behind the read

`timescale 1ns/1ps

module objLineBuffer
	import objPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     lineSwap,
	// Build side
	input  logic     pixWe,
	input  xPosT     pixX,
	input  objPixelT pixValue,
	// Display side
	input  logic     pixRd,
	input  xPosT     hPos,
	output objPixelT objPixel
);

	localparam int lineLen = 2 ** $bits(xPosT);

	// Building bank index, display is the other one
	logic     sel;
	objPixelT bankRd [2];
	logic     opaque;

	assign opaque = (pixValue[$bits(colorT)-1:0] != '0);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			sel <= 1'b0;
		end else if (lineSwap) begin
			sel <= ~sel;
		end
	end

	// ----------------------------------------
	// Banks, one write port each
	// ----------------------------------------
	for (genvar b = 0; b < 2; b++) begin : gBank
		objPixelT mem [lineLen];

		// Buffers power up blank
		initial begin
			for (int i = 0; i < lineLen; i++) begin
				mem[i] = '0;
			end
		end

		always_ff @(posedge clk) begin
			if (sel == 1'(b)) begin
				// Later sprites overwrite, transparent pixels skipped
				if (pixWe && opaque) begin
					mem[pixX] <= pixValue;
				end
			end else if (pixRd) begin
				// Clear behind the display read
				mem[hPos] <= '0;
			end
		end

		assign bankRd[b] = mem[hPos];
	end

	// Registered readout, 0 when no read
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			objPixel <= '0;
		end else begin
			objPixel <= pixRd ? bankRd[~sel] : '0;
		end
	end

endmodule

/* design/objEngine.sv */
// Sprite engine top level
// Attribute table, line scanner, ROM row fetcher and line buffers

`timescale 1ns/1ps

module objEngine
	import objPkg::*;
#(
	parameter int unsigned numSprites = 128,
	parameter romAddrT     romBase    = '0
) (
	input  logic     clk,
	input  logic     rstN,
	// CPU port
	input  cpuAddrT  cpuAddr,
	input  byteT     cpuWrData,
	input  logic     cpuWe,
	output byteT     cpuRdData,
	// Line control
	input  logic     lineStart,
	input  byteT     vPos,
	output logic     busy,
	// Display port
	input  xPosT     hPos,
	input  logic     pixRd,
	output objPixelT objPixel,
	// ROM port
	output romAddrT  romAddr,
	output logic     romReq,
	input  logic     romRdy,
	input  romWordT  romData
);

	// Scanner to table
	cpuAddrT    scanAddr;
	byteT       scanData;
	// Scanner to fetcher
	logic       rowStart;
	tileT       rowTile;
	logic [3:0] rowLine;
	palT        rowPal;
	logic       rowFlip;
	xPosT       rowX;
	logic       rowDone;
	// Into the line buffer
	logic       lineSwap;
	logic       pixWe;
	xPosT       pixX;
	objPixelT   pixValue;

	objAttrRam attrRam (
		.clk(clk), .cpuAddr(cpuAddr), .cpuWrData(cpuWrData), .cpuWe(cpuWe),
		.cpuRdData(cpuRdData), .scanAddr(scanAddr), .scanData(scanData)
	);

	objLineScanner #(.numSprites(numSprites)) scanner (
		.clk(clk), .rstN(rstN), .lineStart(lineStart), .vPos(vPos), .busy(busy),
		.lineSwap(lineSwap), .scanAddr(scanAddr), .scanData(scanData),
		.rowStart(rowStart), .rowTile(rowTile), .rowLine(rowLine), .rowPal(rowPal),
		.rowFlip(rowFlip), .rowX(rowX), .rowDone(rowDone)
	);

	objRowFetcher #(.romBase(romBase)) fetcher (
		.clk(clk), .rstN(rstN), .rowStart(rowStart), .rowTile(rowTile),
		.rowLine(rowLine), .rowPal(rowPal), .rowFlip(rowFlip), .rowX(rowX),
		.rowDone(rowDone), .romAddr(romAddr), .romReq(romReq), .romRdy(romRdy),
		.romData(romData), .pixWe(pixWe), .pixX(pixX), .pixValue(pixValue)
	);

	objLineBuffer lineBuf (
		.clk(clk), .rstN(rstN), .lineSwap(lineSwap), .pixWe(pixWe), .pixX(pixX),
		.pixValue(pixValue), .pixRd(pixRd), .hPos(hPos), .objPixel(objPixel)
	);

endmodule

/* verif/objEngine_chk.sv */
// Sprite engine protocol checker
// Bound to objEngine: reset state, ROM request ordering, start of busy

`timescale 1ns/1ps

module objEngine_chk (
	input logic clk,
	input logic rstN,
	input logic lineStart,
	input logic busy,
	input logic romReq,
	input logic romRdy
);

	// Failed assertions so far, read by the testbench
	int unsigned failCount = 0;
	// Request out, romRdy not seen yet
	logic        romPending;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			romPending <= 1'b0;
		end else if (romReq) begin
			romPending <= 1'b1;
		end else if (romRdy) begin
			romPending <= 1'b0;
		end
	end

	// ----------------------------------------
	// Properties
	// ----------------------------------------
	resetQuiet: assert property (@(posedge clk) $rose(rstN) |-> (!busy && !romReq))
		else begin
			failCount++;
			$error("busy or romReq high out of reset");
		end

	// One outstanding ROM request at most
	oneRequest: assert property (@(posedge clk) disable iff (!rstN) romPending |-> !romReq)
		else begin
			failCount++;
			$error("romReq issued before romRdy of the previous request");
		end

	busyStart: assert property (@(posedge clk) disable iff (!rstN) $rose(busy) |-> $past(lineStart))
		else begin
			failCount++;
			$error("busy rose without lineStart");
		end

endmodule

bind objEngine objEngine_chk chk (
	.clk(clk), .rstN(rstN), .lineStart(lineStart), .busy(busy),
	.romReq(romReq), .romRdy(romRdy)
);

/* verif/objEngineTb.sv */
// Sprite engine testbench
// Directed tests with a random-latency ROM model and a line reference model

`timescale 1ns/1ps

module objEngineTb
	import objPkg::*;
;

	localparam int numSprites    = 128;
	// About ten worst-case builds of 128 entries
	localparam int timeoutCycles = 60000;
	// Lines for the build and for the readout that draws nothing
	localparam byteT mainV = 8'd20;
	localparam byteT readV = 8'd100;

	logic     clk = 1'b0;
	logic     rstN;
	cpuAddrT  cpuAddr;
	byteT     cpuWrData;
	logic     cpuWe;
	byteT     cpuRdData;
	logic     lineStart;
	byteT     vPos;
	logic     busy;
	xPosT     hPos;
	logic     pixRd;
	objPixelT objPixel;
	romAddrT  romAddr;
	logic     romReq;
	logic     romRdy;
	romWordT  romData;

	// Shadow of the attribute table and the expected line
	byteT     tbl [512];
	objPixelT expLine [256];
	int       cycleCount = 0;

	objEngine #(.numSprites(numSprites), .romBase('0)) dut (
		.clk(clk), .rstN(rstN), .cpuAddr(cpuAddr), .cpuWrData(cpuWrData),
		.cpuWe(cpuWe), .cpuRdData(cpuRdData), .lineStart(lineStart), .vPos(vPos),
		.busy(busy), .hPos(hPos), .pixRd(pixRd), .objPixel(objPixel),
		.romAddr(romAddr), .romReq(romReq), .romRdy(romRdy), .romData(romData)
	);

	always #4 clk = ~clk;

	// ----------------------------------------
	// ROM model
	// ----------------------------------------
	function automatic romWordT romWord(input logic [23:0] wordAddr);
		logic [31:0] prod;
		prod = 32'(wordAddr) * 32'h9e37 + 32'h1234;
		return prod[15:0];
	endfunction

	// Answers each request after 1 to 8 cycles
	always begin
		logic [23:0] reqWord;
		int          lat;
		@(negedge clk);
		if (romReq) begin
			reqWord = romAddr[24:1];
			lat = $urandom_range(8, 1);
			repeat (lat) @(negedge clk);
			romData = romWord(reqWord);
			romRdy = 1'b1;
			@(negedge clk);
			romRdy = 1'b0;
		end
	end

	// Timeout and bound assertion watch
	always @(negedge clk) begin
		cycleCount++;
		if (dut.chk.failCount != 0) begin
			$display("A bound assertion failed, stopping the run");
			$display("ERRORS FOUND");
			$fatal(1, "assertion failure");
		end else if (cycleCount >= timeoutCycles) begin
			$display("Timeout: the run hung after %0d cycles", cycleCount);
			$display("ERRORS FOUND");
			$fatal(1, "timeout");
		end
	end

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			$display("ERRORS FOUND");
			$fatal(1, "first mismatch");
		end
	endtask

	// ----------------------------------------
	// Table and reference model
	// ----------------------------------------
	// Y of 0 keeps an entry off both lines
	task automatic blankTable();
		for (int s = 0; s < numSprites; s++) begin
			tbl[4 * s]     = 8'd0;
			tbl[4 * s + 1] = byteT'($urandom);
			tbl[4 * s + 2] = byteT'($urandom);
			tbl[4 * s + 3] = byteT'($urandom);
		end
	endtask

	// Random bit 7 in byte 1 must be ignored
	task automatic placeSprite(input int s, input byteT y, input tileT tile, input palT pal,
			input logic flip, input xPosT x);
		tbl[4 * s]     = y;
		tbl[4 * s + 1] = {1'($urandom), flip, pal, tile[10:8]};
		tbl[4 * s + 2] = tile[7:0];
		tbl[4 * s + 3] = x;
	endtask

	// Visible sprites painted in table order without color 0
	task automatic computeExpected(input byteT v);
		byteT    row;
		tileT    tile;
		romWordT w;
		colorT   col;
		int      c;
		for (int h = 0; h < 256; h++) begin
			expLine[h] = '0;
		end
		for (int s = 0; s < numSprites; s++) begin
			row = v + tbl[4 * s];
			if (row >= 240) begin
				tile = {tbl[4 * s + 1][2:0], tbl[4 * s + 2]};
				for (int i = 0; i < 16; i++) begin
					c = tbl[4 * s + 1][6] ? 15 - i : i;
					w = romWord(24'({tile, row[3:0], 2'(c / 4)}));
					col = w[15 - 4 * (c % 4) -: 4];
					if (col != 0) begin
						expLine[(int'(tbl[4 * s + 3]) + i) % 256] = {tbl[4 * s + 1][5:3], col};
					end
				end
			end
		end
	endtask

	// ----------------------------------------
	// Bus tasks
	// ----------------------------------------
	task automatic writeTable();
		for (int a = 0; a < 512; a++) begin
			cpuAddr = cpuAddrT'(a);
			cpuWrData = tbl[a];
			cpuWe = 1'b1;
			@(negedge clk);
		end
		cpuWe = 1'b0;
	endtask

	// Optional second lineStart while busy must be ignored
	task automatic buildLine(input byteT v, input logic pokeBusy);
		writeTable();
		computeExpected(v);
		lineStart = 1'b1;
		vPos = v;
		@(negedge clk);
		lineStart = 1'b0;
		checkEq("busy", busy, 1);
		if (pokeBusy) begin
			repeat (3) @(negedge clk);
			lineStart = 1'b1;
			vPos = v + 8'd7;
			@(negedge clk);
			lineStart = 1'b0;
		end
		while (busy) @(negedge clk);
	endtask

	// Next line swaps and all 256 columns read back
	task automatic readLine();
		int probe;
		probe = 0;
		for (int h = 255; h >= 0; h--) begin
			if (expLine[h] != '0) begin
				probe = h;
			end
		end
		lineStart = 1'b1;
		vPos = readV;
		hPos = xPosT'(probe);
		@(negedge clk);
		lineStart = 1'b0;
		// No pixRd yet so a drawn column still reads 0
		@(negedge clk);
		checkEq("objPixel idle", objPixel, 0);
		pixRd = 1'b1;
		hPos = '0;
		for (int h = 0; h < 256; h++) begin
			@(negedge clk);
			checkEq($sformatf("objPixel[%0d]", h), objPixel, expLine[h]);
			hPos = xPosT'(h + 1);
		end
		pixRd = 1'b0;
		while (busy) @(negedge clk);
	endtask

	// ----------------------------------------
	// Tests
	// ----------------------------------------
	task automatic cpuPortRoundTrip();
		byteT    vals [64];
		cpuAddrT addrs [64];
		for (int i = 0; i < 64; i++) begin
			addrs[i] = cpuAddrT'(i * 8 + $urandom_range(7, 0));
			vals[i] = byteT'($urandom);
			cpuAddr = addrs[i];
			cpuWrData = vals[i];
			cpuWe = 1'b1;
			@(negedge clk);
		end
		cpuWe = 1'b0;
		for (int i = 0; i < 64; i++) begin
			cpuAddr = addrs[i];
			@(negedge clk);
			checkEq($sformatf("cpuRdData@%0h", addrs[i]), cpuRdData, vals[i]);
		end
	endtask

	task automatic singleSprite(input logic flip);
		blankTable();
		placeSprite(5, 8'd230, 11'h2a5, 3'd3, flip, 8'd40);
		buildLine(mainV, 1'b0);
		readLine();
	endtask

	// Later sprite wins where opaque and the Y=200 entry stays hidden
	task automatic overlapAndHidden();
		blankTable();
		placeSprite(3, 8'd232, 11'h13c, 3'd5, 1'b0, 8'd100);
		placeSprite(9, 8'd224, 11'h7f1, 3'd2, 1'b1, 8'd108);
		placeSprite(20, 8'd200, 11'h055, 3'd6, 1'b0, 8'd150);
		buildLine(mainV, 1'b0);
		readLine();
	endtask

	// Bank read by the previous readout comes back empty
	task automatic readClears();
		blankTable();
		buildLine(mainV, 1'b0);
		readLine();
	endtask

	// Same scene under new latencies plus an ignored lineStart in each build
	task automatic latencyAndBusyPoke();
		blankTable();
		placeSprite(7, 8'd228, 11'h3e9, 3'd4, 1'b1, 8'd250);
		placeSprite(60, 8'd235, 11'h4d2, 3'd1, 1'b0, 8'd246);
		repeat (3) begin
			buildLine(mainV, 1'b1);
			readLine();
		end
	endtask

	initial begin
		void'($urandom(32'ha330));
		rstN = 1'b0;
		cpuAddr = '0;
		cpuWrData = '0;
		cpuWe = 1'b0;
		lineStart = 1'b0;
		vPos = '0;
		hPos = '0;
		pixRd = 1'b0;
		romRdy = 1'b0;
		romData = '0;
		repeat (4) @(negedge clk);
		rstN = 1'b1;
		@(negedge clk);
		checkEq("busy after reset", busy, 0);
		cpuPortRoundTrip();
		singleSprite(1'b0);
		singleSprite(1'b1);
		overlapAndHidden();
		readClears();
		latencyAndBusyPoke();
		@(negedge clk);
		if (dut.chk.failCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* objEngine.f */
design/objPkg.sv
design/objAttrRam.sv
design/objLineScanner.sv
design/objRowFetcher.sv
design/objLineBuffer.sv
design/objEngine.sv
verif/objEngine_chk.sv
verif/objEngineTb.sv
